/* design/rv32i_types.sv */
package rv32i_types;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_br    = 7'b1100011
    } rv32i_opcode;

    // funct3 of register and immediate arithmetic
    typedef enum logic [2:0] {
        arith_add = 3'b000,
        arith_slt = 3'b010,
        arith_xor = 3'b100,
        arith_or  = 3'b110,
        arith_and = 3'b111
    } arith_funct3_t;

    typedef enum logic [2:0] {
        br_eq = 3'b000,
        br_ne = 3'b001
    } branch_funct3_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_ops;

    // addi x0, x0, 0
    localparam rv32i_word nop_instr = 32'h0000_0013;

endpackage : rv32i_types

/* design/pipeline_pkg.sv */
package pipeline_pkg;

    // control consumed in execute
    typedef struct packed {
        rv32i_types::alu_ops alu_op;
        logic                use_imm;
        logic                is_branch;
        logic                branch_ne;
    } ctrlex_t;

    // control consumed in memory
    typedef struct packed {
        logic dmem_read;
        logic dmem_write;
    } ctrlmem_t;

    // control consumed in writeback
    typedef struct packed {
        logic                  reg_write;
        logic                  mem_to_reg;
        rv32i_types::rv32i_reg rd;
    } ctrlwb_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_ex_mem,
        fwd_mem_wb
    } fwd_sel_t;

    typedef struct packed {
        logic load_pc;
        logic load_if_id;
        logic load_id_ex;
        logic load_ex_mem;
        logic load_mem_wb;
        logic flush_if_id;
        logic flush_id_ex;
    } hazard_ctrl_t;

    localparam rv32i_types::rv32i_word reset_pc = 32'h0000_0000;

endpackage : pipeline_pkg

/* design/ctrl_word.sv */
`timescale 1ns/1ps

module ctrl_word (
    input  logic                     clk,
    input  logic                     rst,
    input  rv32i_types::rv32i_opcode opcode,
    input  logic [2:0]               funct3,
    input  logic [6:0]               funct7,
    input  rv32i_types::rv32i_reg    rd_in,
    input  pipeline_pkg::hazard_ctrl_t hazard_ctrl,
    output pipeline_pkg::ctrlex_t    ctrlex,
    output pipeline_pkg::ctrlmem_t   ctrlmem,
    output pipeline_pkg::ctrlmem_t   ctrlmem_at_mem,
    output pipeline_pkg::ctrlwb_t    ctrlwb_at_ex,
    output pipeline_pkg::ctrlwb_t    ctrlwb_at_mem,
    output pipeline_pkg::ctrlwb_t    ctrlwb
);

    pipeline_pkg::ctrlex_t  ex_id;
    pipeline_pkg::ctrlmem_t mem_id, ctrlmem_at_ex;
    pipeline_pkg::ctrlwb_t  wb_id;

    // funct7[5] only selects sub for register ops
    function automatic rv32i_types::alu_ops arith_op(input logic [2:0] f3, input logic sub);
        case (rv32i_types::arith_funct3_t'(f3))
            rv32i_types::arith_slt: return rv32i_types::alu_slt;
            rv32i_types::arith_xor: return rv32i_types::alu_xor;
            rv32i_types::arith_or:  return rv32i_types::alu_or;
            rv32i_types::arith_and: return rv32i_types::alu_and;
            default:                return sub ? rv32i_types::alu_sub : rv32i_types::alu_add;
        endcase
    endfunction

    // decode, anything unknown stays a bubble
    always_comb begin
        ex_id  = '0;
        mem_id = '0;
        wb_id  = '0;
        case (opcode)
            rv32i_types::op_reg: begin
                ex_id.alu_op    = arith_op(funct3, funct7[5]);
                wb_id.reg_write = 1'b1;
                wb_id.rd        = rd_in;
            end
            rv32i_types::op_imm: begin
                ex_id.alu_op    = arith_op(funct3, 1'b0);
                ex_id.use_imm   = 1'b1;
                wb_id.reg_write = 1'b1;
                wb_id.rd        = rd_in;
            end
            rv32i_types::op_lui: begin
                // rs1 reads x0, so add passes the immediate
                ex_id.use_imm   = 1'b1;
                wb_id.reg_write = 1'b1;
                wb_id.rd        = rd_in;
            end
            rv32i_types::op_load: begin
                ex_id.use_imm    = 1'b1;
                mem_id.dmem_read = 1'b1;
                wb_id.reg_write  = 1'b1;
                wb_id.mem_to_reg = 1'b1;
                wb_id.rd         = rd_in;
            end
            rv32i_types::op_store: begin
                ex_id.use_imm     = 1'b1;
                mem_id.dmem_write = 1'b1;
            end
            rv32i_types::op_br: begin
                ex_id.is_branch = 1'b1;
                ex_id.branch_ne =
                    (rv32i_types::branch_funct3_t'(funct3) == rv32i_types::br_ne);
            end
            default: begin
            end
        endcase
    end

    // ID/EX, bubble on flush
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrlex        <= '0;
            ctrlmem_at_ex <= '0;
            ctrlwb_at_ex  <= '0;
        end else if (hazard_ctrl.load_id_ex) begin
            ctrlex        <= hazard_ctrl.flush_id_ex ? '0 : ex_id;
            ctrlmem_at_ex <= hazard_ctrl.flush_id_ex ? '0 : mem_id;
            ctrlwb_at_ex  <= hazard_ctrl.flush_id_ex ? '0 : wb_id;
        end
    end

    // EX/MEM and MEM/WB
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrlmem       <= '0;
            ctrlwb_at_mem <= '0;
            ctrlwb        <= '0;
        end else begin
            if (hazard_ctrl.load_ex_mem) begin
                ctrlmem       <= ctrlmem_at_ex;
                ctrlwb_at_mem <= ctrlwb_at_ex;
            end
            if (hazard_ctrl.load_mem_wb) begin
                ctrlwb <= ctrlwb_at_mem;
            end
        end
    end

    assign ctrlmem_at_mem = ctrlmem;

endmodule : ctrl_word

/* design/datapath.sv */
`timescale 1ns/1ps

module datapath (
    input  logic                       clk,
    input  logic                       rst,
    input  rv32i_types::rv32i_word     imem_rdata,
    input  rv32i_types::rv32i_word     dmem_rdata,
    input  pipeline_pkg::ctrlex_t      ctrlex,
    input  pipeline_pkg::ctrlmem_t     ctrlmem,
    input  pipeline_pkg::ctrlwb_t      ctrlwb,
    input  pipeline_pkg::fwd_sel_t     fwdmux1_sel,
    input  pipeline_pkg::fwd_sel_t     fwdmux2_sel,
    input  pipeline_pkg::hazard_ctrl_t hazard_ctrl,
    output rv32i_types::rv32i_word     imem_address,
    output rv32i_types::rv32i_word     dmem_address,
    output rv32i_types::rv32i_word     dmem_wdata,
    output logic [3:0]                 dmem_wmask,
    output rv32i_types::rv32i_opcode   opcode,
    output logic [2:0]                 funct3,
    output logic [6:0]                 funct7,
    output rv32i_types::rv32i_reg      rd_in,
    output rv32i_types::rv32i_reg      rs1_in,
    output rv32i_types::rv32i_reg      rs2_in,
    output rv32i_types::rv32i_reg      rs1_at_ex,
    output rv32i_types::rv32i_reg      rs2_at_ex,
    output logic                       ex_branch_taken
);

    rv32i_types::rv32i_word pc, pc_id, instr_id, imm_id, rs1_val_id, rs2_val_id;
    rv32i_types::rv32i_word pc_ex, rs1_val_ex, rs2_val_ex, imm_ex;
    rv32i_types::rv32i_word alu_a, fwd_b, alu_b, alu_out, branch_target;
    rv32i_types::rv32i_word alu_out_mem, store_data_mem;
    rv32i_types::rv32i_word alu_out_wb, mem_data_wb, wb_data;
    rv32i_types::rv32i_word regs [32];

    // x0 reads zero, a write in the same cycle is bypassed
    function automatic rv32i_types::rv32i_word rf_read(input rv32i_types::rv32i_reg idx);
        if (idx == 5'd0) begin
            return '0;
        end
        if (ctrlwb.reg_write && ctrlwb.rd == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    function automatic rv32i_types::rv32i_word fwd_pick(
        input pipeline_pkg::fwd_sel_t sel,
        input rv32i_types::rv32i_word reg_val,
        input rv32i_types::rv32i_word mem_val,
        input rv32i_types::rv32i_word wb_val
    );
        case (sel)
            pipeline_pkg::fwd_ex_mem: return mem_val;
            pipeline_pkg::fwd_mem_wb: return wb_val;
            default:                  return reg_val;
        endcase
    endfunction

    // fetch
    assign imem_address = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= pipeline_pkg::reset_pc;
        end else if (hazard_ctrl.load_pc) begin
            pc <= ex_branch_taken ? branch_target : pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instr_id <= rv32i_types::nop_instr;
        end else if (hazard_ctrl.load_if_id) begin
            instr_id <= hazard_ctrl.flush_if_id ? rv32i_types::nop_instr : imem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (hazard_ctrl.load_if_id) begin
            pc_id <= pc;
        end
    end

    // decode
    assign opcode = rv32i_types::rv32i_opcode'(instr_id[6:0]);
    assign funct3 = instr_id[14:12];
    assign funct7 = instr_id[31:25];
    assign rd_in  = instr_id[11:7];

    // unused source fields are zeroed so they never forward or stall
    assign rs1_in = (opcode == rv32i_types::op_lui) ? 5'd0 : instr_id[19:15];
    assign rs2_in = (opcode == rv32i_types::op_reg || opcode == rv32i_types::op_store ||
                     opcode == rv32i_types::op_br) ? instr_id[24:20] : 5'd0;

    always_comb begin
        case (opcode)
            rv32i_types::op_store:
                imm_id = {{20{instr_id[31]}}, instr_id[31:25], instr_id[11:7]};
            rv32i_types::op_br:
                imm_id = {{19{instr_id[31]}}, instr_id[31], instr_id[7],
                          instr_id[30:25], instr_id[11:8], 1'b0};
            rv32i_types::op_lui:
                imm_id = {instr_id[31:12], 12'h000};
            default:
                imm_id = {{20{instr_id[31]}}, instr_id[31:20]};
        endcase
    end

    always_comb begin
        rs1_val_id = rf_read(rs1_in);
        rs2_val_id = rf_read(rs2_in);
    end

    always_ff @(posedge clk) begin
        if (ctrlwb.reg_write && ctrlwb.rd != 5'd0) begin
            regs[ctrlwb.rd] <= wb_data;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        if (hazard_ctrl.load_id_ex) begin
            pc_ex      <= pc_id;
            rs1_val_ex <= rs1_val_id;
            rs2_val_ex <= rs2_val_id;
            imm_ex     <= imm_id;
            rs1_at_ex  <= rs1_in;
            rs2_at_ex  <= rs2_in;
        end
    end

    // execute
    assign alu_a = fwd_pick(fwdmux1_sel, rs1_val_ex, alu_out_mem, wb_data);
    assign fwd_b = fwd_pick(fwdmux2_sel, rs2_val_ex, alu_out_mem, wb_data);
    assign alu_b = ctrlex.use_imm ? imm_ex : fwd_b;

    always_comb begin
        case (ctrlex.alu_op)
            rv32i_types::alu_sub: alu_out = alu_a - alu_b;
            rv32i_types::alu_and: alu_out = alu_a & alu_b;
            rv32i_types::alu_or:  alu_out = alu_a | alu_b;
            rv32i_types::alu_xor: alu_out = alu_a ^ alu_b;
            rv32i_types::alu_slt: alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
            default:              alu_out = alu_a + alu_b;
        endcase
    end

    assign branch_target   = pc_ex + imm_ex;
    assign ex_branch_taken = ctrlex.is_branch && ((alu_a == fwd_b) ^ ctrlex.branch_ne);

    // memory
    always_ff @(posedge clk) begin
        if (hazard_ctrl.load_ex_mem) begin
            alu_out_mem    <= alu_out;
            store_data_mem <= fwd_b;
        end
    end

    assign dmem_address = alu_out_mem;
    assign dmem_wdata   = store_data_mem;
    assign dmem_wmask   = ctrlmem.dmem_write ? 4'hf : 4'h0;

    // writeback
    always_ff @(posedge clk) begin
        if (hazard_ctrl.load_mem_wb) begin
            alu_out_wb  <= alu_out_mem;
            mem_data_wb <= dmem_rdata;
        end
    end

    assign wb_data = ctrlwb.mem_to_reg ? mem_data_wb : alu_out_wb;

endmodule : datapath

/* design/forwarding_unit.sv */
`timescale 1ns/1ps

module forwarding_unit (
    input  rv32i_types::rv32i_reg  rs1_in,
    input  rv32i_types::rv32i_reg  rs2_in,
    input  rv32i_types::rv32i_reg  rs1_at_ex,
    input  rv32i_types::rv32i_reg  rs2_at_ex,
    input  pipeline_pkg::ctrlwb_t  ctrlwb_at_ex,
    input  pipeline_pkg::ctrlwb_t  ctrlwb_at_mem,
    input  pipeline_pkg::ctrlwb_t  ctrlwb,
    output pipeline_pkg::fwd_sel_t fwdmux1_sel,
    output pipeline_pkg::fwd_sel_t fwdmux2_sel,
    output logic                   load_use_stall
);

    // youngest producer wins, x0 never forwards
    function automatic pipeline_pkg::fwd_sel_t pick(
        input rv32i_types::rv32i_reg rs,
        input pipeline_pkg::ctrlwb_t at_mem,
        input pipeline_pkg::ctrlwb_t at_wb
    );
        if (rs != 5'd0 && at_mem.reg_write && at_mem.rd == rs) begin
            return pipeline_pkg::fwd_ex_mem;
        end
        if (rs != 5'd0 && at_wb.reg_write && at_wb.rd == rs) begin
            return pipeline_pkg::fwd_mem_wb;
        end
        return pipeline_pkg::fwd_none;
    endfunction

    assign fwdmux1_sel = pick(rs1_at_ex, ctrlwb_at_mem, ctrlwb);
    assign fwdmux2_sel = pick(rs2_at_ex, ctrlwb_at_mem, ctrlwb);

    // load data only exists after MEM, one bubble needed
    assign load_use_stall = ctrlwb_at_ex.reg_write && ctrlwb_at_ex.mem_to_reg &&
                            ctrlwb_at_ex.rd != 5'd0 &&
                            (ctrlwb_at_ex.rd == rs1_in || ctrlwb_at_ex.rd == rs2_in);

endmodule : forwarding_unit

/* design/hazard_ctrl_unit.sv */
`timescale 1ns/1ps

module hazard_ctrl_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       imem_resp,
    input  logic                       dmem_resp,
    input  pipeline_pkg::ctrlmem_t     ctrlmem_at_mem,
    input  logic                       load_use_stall,
    input  logic                       ex_branch_taken,
    output pipeline_pkg::hazard_ctrl_t hazard_ctrl,
    output logic                       imem_read,
    output logic                       dmem_read,
    output logic                       dmem_write
);

    // st_wait means this port's access is done and it waits for the other port
    typedef enum logic {
        st_idle,
        st_wait
    } port_state_t;

    port_state_t imem_state, dmem_state;
    logic        dmem_need, imem_done, dmem_done, advance;

    assign dmem_need  = ctrlmem_at_mem.dmem_read || ctrlmem_at_mem.dmem_write;
    assign imem_read  = (imem_state == st_idle);
    assign dmem_read  = ctrlmem_at_mem.dmem_read && (dmem_state == st_idle);
    assign dmem_write = ctrlmem_at_mem.dmem_write && (dmem_state == st_idle);

    assign imem_done = (imem_state == st_wait) || (imem_read && imem_resp);
    assign dmem_done = !dmem_need || (dmem_state == st_wait) ||
                       ((dmem_read || dmem_write) && dmem_resp);

    // global freeze until both ports are done
    assign advance = imem_done && dmem_done;

    // a port that finished early relies on rdata holding until its next request
    always_ff @(posedge clk) begin
        if (rst || advance) begin
            imem_state <= st_idle;
            dmem_state <= st_idle;
        end else begin
            if (imem_read && imem_resp) begin
                imem_state <= st_wait;
            end
            if ((dmem_read || dmem_write) && dmem_resp) begin
                dmem_state <= st_wait;
            end
        end
    end

    always_comb begin
        hazard_ctrl = '0;
        if (advance) begin
            hazard_ctrl.load_id_ex  = 1'b1;
            hazard_ctrl.load_ex_mem = 1'b1;
            hazard_ctrl.load_mem_wb = 1'b1;
            // taken branch overrides the load-use hold
            hazard_ctrl.load_pc     = ex_branch_taken || !load_use_stall;
            hazard_ctrl.load_if_id  = ex_branch_taken || !load_use_stall;
            hazard_ctrl.flush_if_id = ex_branch_taken;
            hazard_ctrl.flush_id_ex = ex_branch_taken || load_use_stall;
        end
    end

endmodule : hazard_ctrl_unit

/* design/cpu.sv */
`timescale 1ns/1ps

module cpu (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   imem_resp,
    input  logic                   dmem_resp,
    input  rv32i_types::rv32i_word imem_rdata,
    input  rv32i_types::rv32i_word dmem_rdata,
    output logic                   imem_read,
    output logic                   dmem_read,
    output logic                   dmem_write,
    output logic [3:0]             dmem_wmask,
    output rv32i_types::rv32i_word imem_address,
    output rv32i_types::rv32i_word dmem_address,
    output rv32i_types::rv32i_word dmem_wdata
);

    // control words, each at the stage that uses it
    pipeline_pkg::ctrlex_t  ctrlex;
    pipeline_pkg::ctrlmem_t ctrlmem, ctrlmem_at_mem;
    pipeline_pkg::ctrlwb_t  ctrlwb_at_ex, ctrlwb_at_mem, ctrlwb;

    // instruction fields from ID
    rv32i_types::rv32i_opcode opcode;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    rv32i_types::rv32i_reg    rd_in, rs1_in, rs2_in;
    rv32i_types::rv32i_reg    rs1_at_ex, rs2_at_ex;

    pipeline_pkg::fwd_sel_t     fwdmux1_sel, fwdmux2_sel;
    pipeline_pkg::hazard_ctrl_t hazard_ctrl;
    logic                       load_use_stall;
    logic                       ex_branch_taken;

    datapath datapath (.*);

    ctrl_word ctrl_word (.*);

    forwarding_unit forwarding_unit (.*);

    hazard_ctrl_unit hazard_ctrl_unit (.*);

endmodule : cpu

/* sim/cpu_checker.sv */
`timescale 1ns/1ps

module cpu_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   imem_read,
    input  rv32i_types::rv32i_word imem_address,
    input  logic                   dmem_read,
    input  logic                   dmem_write,
    input  logic                   dmem_resp,
    input  logic [3:0]             dmem_wmask,
    input  rv32i_types::rv32i_word dmem_address,
    input  rv32i_types::rv32i_word dmem_wdata,
    input  rv32i_types::rv32i_word prog [256],
    input  rv32i_types::rv32i_word data [1024],
    output int                     errors,
    output logic                   done
);

    rv32i_types::rv32i_word exp_addr [$];
    rv32i_types::rv32i_word exp_data [$];
    int                     limit, cycles, next_store;
    logic                   fresh_reset;

    // ISA level run of the program that collects every store in order
    function automatic int run_reference();
        rv32i_types::rv32i_word x [32];
        rv32i_types::rv32i_word mem [1024];
        rv32i_types::rv32i_word pc, next, ins, a, b, op2, imm, res, addr;
        logic                   wr, is_reg;
        int                     steps;
        x   = '{default: '0};
        mem = data;
        pc  = '0;
        for (steps = 1; steps < 2000; steps++) begin
            ins    = prog[pc[9:2]];
            next   = pc + 32'd4;
            a      = x[ins[19:15]];
            b      = x[ins[24:20]];
            imm    = {{20{ins[31]}}, ins[31:20]};
            is_reg = (ins[6:0] == rv32i_types::op_reg);
            op2    = is_reg ? b : imm;
            wr     = 1'b1;
            res    = '0;
            case (rv32i_types::rv32i_opcode'(ins[6:0]))
                rv32i_types::op_reg, rv32i_types::op_imm: begin
                    case (ins[14:12])
                        3'b000:  res = (is_reg && ins[30]) ? a - op2 : a + op2;
                        3'b010:  res = {31'b0, $signed(a) < $signed(op2)};
                        3'b100:  res = a ^ op2;
                        3'b110:  res = a | op2;
                        default: res = a & op2;
                    endcase
                end
                rv32i_types::op_lui: res = {ins[31:12], 12'h000};
                rv32i_types::op_load: begin
                    addr = a + imm;
                    res  = mem[addr[11:2]];
                end
                rv32i_types::op_store: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    mem[addr[11:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    wr = 1'b0;
                    if (addr == 32'h0000_0ff0) begin
                        return steps;
                    end
                end
                rv32i_types::op_br: begin
                    wr = 1'b0;
                    // funct3 bit 0 turns beq into bne
                    if ((a == b) != ins[12]) begin
                        next = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                     ins[11:8], 1'b0};
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                x[ins[11:7]] = res;
            end
            pc = next;
        end
        return steps;
    endfunction

    initial begin
        @(negedge rst);
        limit = 4 * 40 * run_reference();
    end

    always @(negedge clk) begin
        if (rst) begin
            errors      = 0;
            done        = 1'b0;
            cycles      = 0;
            next_store  = 0;
            fresh_reset = 1'b1;
        end else if (!done) begin
            cycles++;
            // first fetch from address zero pending with no data access yet
            if (fresh_reset && (!imem_read || dmem_read || dmem_write ||
                                imem_address != 32'd0)) begin
                $display("Fail %0t: after reset imem_read %b dmem_read %b dmem_write %b pc %h",
                         $time, imem_read, dmem_read, dmem_write, imem_address);
                errors++;
            end
            fresh_reset = 1'b0;
            if (dmem_write && dmem_resp) begin
                if (next_store >= exp_addr.size()) begin
                    $display("an extra store of %h to %h came after all expected stores",
                             dmem_wdata, dmem_address);
                    errors++;
                end else if (dmem_address != exp_addr[next_store] ||
                             dmem_wdata != exp_data[next_store] || dmem_wmask != 4'hf) begin
                    $display("Fail %0t: store %0d wrote %h to %h mask %b, expected %h to %h",
                             $time, next_store, dmem_wdata, dmem_address, dmem_wmask,
                             exp_data[next_store], exp_addr[next_store]);
                    errors++;
                end
                next_store++;
                if (dmem_address == 32'h0000_0ff0) begin
                    if (next_store != exp_addr.size()) begin
                        $display("the final store came as store %0d of %0d expected",
                                 next_store, exp_addr.size());
                        errors++;
                    end
                    done = 1'b1;
                end
            end
            if (!done && cycles >= limit) begin
                $display("the program did not reach its final store within %0d cycles",
                         limit);
                errors++;
                done = 1'b1;
            end
        end
    end

endmodule : cpu_checker

/* sim/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

    logic                   clk, rst;
    logic                   imem_resp, dmem_resp;
    logic                   imem_read, dmem_read, dmem_write;
    logic [3:0]             dmem_wmask;
    rv32i_types::rv32i_word imem_rdata, dmem_rdata;
    rv32i_types::rv32i_word imem_address, dmem_address, dmem_wdata;

    rv32i_types::rv32i_word imem [256];
    rv32i_types::rv32i_word dmem [1024];
    int                     prog_len;
    int                     errors;
    logic                   done;

    cpu cpu_inst (.*);

    cpu_checker checker_inst (
        .clk, .rst, .imem_read, .imem_address, .dmem_read, .dmem_write, .dmem_resp,
        .dmem_wmask, .dmem_address, .dmem_wdata,
        .prog (imem), .data (dmem), .errors, .done
    );

    // instruction encoders
    function automatic rv32i_types::rv32i_word alu_rr(input int f7, f3, rd, rs1, rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv32i_types::op_reg};
    endfunction

    function automatic rv32i_types::rv32i_word addi(input int rd, rs1, imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], rv32i_types::op_imm};
    endfunction

    function automatic rv32i_types::rv32i_word lw(input int rd, rs1, imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], rv32i_types::op_load};
    endfunction

    function automatic rv32i_types::rv32i_word sw(input int rs2, rs1, imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rv32i_types::op_store};
    endfunction

    function automatic rv32i_types::rv32i_word lui(input int rd, upper);
        return {upper[19:0], rd[4:0], rv32i_types::op_lui};
    endfunction

    function automatic rv32i_types::rv32i_word branch(input int f3, rs1, rs2, off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                rv32i_types::op_br};
    endfunction

    task automatic emit(input rv32i_types::rv32i_word instr);
        imem[prog_len] = instr;
        prog_len++;
    endtask

    task automatic load_program();
        int stored [9] = '{2, 3, 4, 6, 7, 8, 9, 11, 12};
        for (int k = 0; k < 256; k++) begin
            imem[k] = rv32i_types::nop_instr;
        end
        prog_len = 0;
        // dependent chain through both forwarding paths
        emit(addi(1, 0, 5));
        emit(addi(2, 1, 7));
        emit(alu_rr(0, 0, 3, 1, 2));
        emit(alu_rr(32'h20, 0, 4, 3, 1));
        emit(lui(5, 32'h12345));
        emit(alu_rr(0, 4, 6, 5, 4));
        emit(alu_rr(0, 6, 7, 6, 3));
        emit(alu_rr(0, 7, 8, 7, 5));
        emit(alu_rr(0, 2, 9, 4, 3));
        emit(addi(10, 0, -3));
        emit(alu_rr(0, 2, 11, 10, 1));
        emit(alu_rr(0, 2, 12, 1, 10));
        emit(addi(20, 0, 32'h100));
        for (int k = 0; k < 9; k++) begin
            emit(sw(stored[k], 20, 4 * k));
        end
        // load followed by its use
        emit(lw(13, 0, 32'h200));
        emit(addi(14, 13, 1));
        emit(sw(14, 20, 36));
        emit(lw(15, 20, 4));
        emit(alu_rr(0, 0, 16, 15, 15));
        emit(sw(16, 20, 40));
        emit(sw(15, 20, 44));
        // x0 stays zero
        emit(addi(0, 0, 99));
        emit(alu_rr(0, 0, 0, 1, 2));
        emit(sw(0, 20, 48));
        // branch shadows hold stores and writes that must vanish
        emit(branch(0, 1, 2, 8));
        emit(sw(1, 20, 52));
        emit(branch(1, 1, 2, 12));
        emit(sw(2, 20, 56));
        emit(addi(1, 0, 77));
        emit(addi(17, 0, 1));
        emit(addi(18, 0, 9));
        emit(branch(0, 18, 18, 12));
        emit(sw(3, 20, 60));
        emit(addi(17, 17, 100));
        emit(sw(17, 20, 64));
        emit(branch(1, 4, 4, 8));
        emit(addi(17, 17, 2));
        emit(sw(17, 20, 68));
        // backward loop with four stores
        emit(addi(21, 0, 4));
        emit(addi(22, 20, 32'h80));
        emit(sw(21, 22, 0));
        emit(addi(22, 22, 4));
        emit(addi(21, 21, -1));
        emit(branch(1, 21, 0, -12));
        // load straight into a taken branch
        emit(lw(23, 20, 32'h80));
        emit(branch(1, 23, 21, 8));
        emit(sw(21, 20, 72));
        emit(sw(23, 20, 76));
        // final store to 0xff0
        emit(lui(24, 1));
        emit(addi(24, 24, -16));
        emit(sw(1, 24, 0));
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // both memories answer 1 to 3 cycles after they see a request
    initial begin : memory_model
        int   i_cnt, d_cnt;
        logic i_busy, d_busy, held_rst;
        void'($urandom(32'h60acdabf));
        imem_resp  = 1'b0;
        dmem_resp  = 1'b0;
        imem_rdata = rv32i_types::nop_instr;
        dmem_rdata = '0;
        i_busy     = 1'b0;
        d_busy     = 1'b0;
        i_cnt      = 0;
        d_cnt      = 0;
        for (int k = 0; k < 1024; k++) begin
            dmem[k] = (k * 32'h9e37_79b9) ^ 32'h0000_5a5a;
        end
        forever begin
            @(posedge clk);
            held_rst = rst;
            #1;
            // resp high in the last cycle means that transfer just completed
            if (imem_resp || held_rst) begin
                imem_resp = 1'b0;
                i_busy    = 1'b0;
            end
            if (dmem_resp || held_rst) begin
                dmem_resp = 1'b0;
                d_busy    = 1'b0;
            end
            if (!held_rst && i_busy) begin
                i_cnt--;
                if (i_cnt == 0) begin
                    imem_rdata = imem[imem_address[9:2]];
                    imem_resp  = 1'b1;
                end
            end else if (!held_rst && imem_read) begin
                i_busy = 1'b1;
                i_cnt  = $urandom_range(3, 1);
            end
            if (!held_rst && d_busy) begin
                d_cnt--;
                if (d_cnt == 0) begin
                    if (dmem_write) begin
                        dmem[dmem_address[11:2]] = dmem_wdata;
                    end else begin
                        dmem_rdata = dmem[dmem_address[11:2]];
                    end
                    dmem_resp = 1'b1;
                end
            end else if (!held_rst && (dmem_read || dmem_write)) begin
                d_busy = 1'b1;
                d_cnt  = $urandom_range(3, 1);
            end
        end
    end

    initial begin
        rst = 1'b1;
        load_program();
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        wait (done === 1'b1);
        $display("run finished with %0d error(s)", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : cpu_tb

/* list.f */
design/rv32i_types.sv
design/pipeline_pkg.sv
design/ctrl_word.sv
design/datapath.sv
design/forwarding_unit.sv
design/hazard_ctrl_unit.sv
design/cpu.sv
sim/cpu_checker.sv
sim/cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator, verdict taken from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary -f list.f --top-module cpu_tb -o cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cpu_sim | tee sim.log
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if grep -qF "*** PASSED ***" sim.log; then
    exit 0
fi
exit 1
